//--- Makefile
TOOL := verilator
FLAGS := --binary --timing --assert
TOP := tb_mem_system
FILELIST := build.f
OBJ_DIR := obj_dir
SIM := $(OBJ_DIR)/V$(TOP)
PASS_MSG := Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# status comes from the search, the simulator output only goes to the terminal
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- axi_lite_pkg.sv
package axi_lite_pkg;

	localparam int axi_addr_w = 32;
	localparam int axi_data_w = 32;

	// word address sits in bits 17:2 of the byte address
	localparam int axi_word_lsb = 2;
	localparam int axi_word_msb = 17;

	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	typedef struct packed {
		logic awvalid;
		logic [axi_addr_w-1:0] awaddr;
		logic wvalid;
		logic [axi_data_w-1:0] wdata;
		logic [axi_data_w/8-1:0] wstrb;
		logic bready;
		logic arvalid;
		logic [axi_addr_w-1:0] araddr;
		logic rready;
	} axi_lite_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		logic [axi_data_w-1:0] rdata;
		logic [1:0] rresp;
	} axi_lite_rsp_t;

endpackage

//--- build.f
mem_types_pkg.sv
axi_lite_pkg.sv
ram_controller.sv
ram_uart.sv
ram2.sv
mem_system.sv
tb_clock.sv
tb_sram_model.sv
tb_mem_system.sv

//--- mem_system.sv
module mem_system (
	input logic clk,
	input logic rst_n,
	input axi_lite_pkg::axi_lite_req_t axi_req,
	output axi_lite_pkg::axi_lite_rsp_t axi_rsp,
	output mem_types_pkg::sram_bus_t ram1,
	input logic [mem_types_pkg::word_w-1:0] ram1_dq_in,
	output mem_types_pkg::sram_bus_t ram2,
	input logic [mem_types_pkg::word_w-1:0] ram2_dq_in,
	input logic data_ready,
	input logic tbre,
	input logic tsre,
	output logic rdn,
	output logic wrn
);
	import mem_types_pkg::*;

	bank_req_t ram1_req;
	bank_rsp_t ram1_rsp;
	bank_req_t ram2_req;
	bank_rsp_t ram2_rsp;

	ram_controller ram_controller_i (
		.clk(clk),
		.rst_n(rst_n),
		.axi_req(axi_req),
		.axi_rsp(axi_rsp),
		.ram1_req(ram1_req),
		.ram1_rsp(ram1_rsp),
		.ram2_req(ram2_req),
		.ram2_rsp(ram2_rsp)
	);

	// ram1 bank shares its data bus with the uart
	ram_uart ram_uart_i (
		.clk(clk),
		.rst_n(rst_n),
		.req(ram1_req),
		.rsp(ram1_rsp),
		.ram1(ram1),
		.ram1_dq_in(ram1_dq_in),
		.data_ready(data_ready),
		.tbre(tbre),
		.tsre(tsre),
		.rdn(rdn),
		.wrn(wrn)
	);

	ram2 ram2_i (
		.clk(clk),
		.rst_n(rst_n),
		.req(ram2_req),
		.rsp(ram2_rsp),
		.ram2(ram2),
		.ram2_dq_in(ram2_dq_in)
	);

endmodule

//--- mem_types_pkg.sv
package mem_types_pkg;

	// data and word-address width of the memory side
	localparam int word_w = 16;
	// external SRAM address pins
	localparam int sram_addr_w = 18;

	// address map
	localparam logic [word_w-1:0] ram2_limit = 16'h8000;
	localparam logic [7:0] io_page = 8'hBF;
	localparam logic [7:0] uart_data_reg = 8'h00;
	localparam logic [7:0] uart_stat_reg = 8'h01;

	// io view of a word address
	typedef struct packed {
		logic [7:0] page;
		logic [7:0] regsel;
	} io_addr_t;

	// same word read as sram address or as page/register pair
	typedef union packed {
		logic [word_w-1:0] word;
		io_addr_t io;
	} mem_addr_u;

	typedef struct packed {
		logic valid;
		logic write;
		mem_addr_u addr;
		logic [word_w-1:0] wdata;
	} bank_req_t;

	typedef struct packed {
		logic done;
		logic err;
		logic [word_w-1:0] rdata;
	} bank_rsp_t;

	// strobes are active low, data pins split for simulation
	typedef struct packed {
		logic [sram_addr_w-1:0] addr;
		logic en_n;
		logic oe_n;
		logic we_n;
		logic [word_w-1:0] data_out;
		logic data_oe;
	} sram_bus_t;

endpackage

//--- ram2.sv
module ram2 (
	input logic clk,
	input logic rst_n,
	input mem_types_pkg::bank_req_t req,
	output mem_types_pkg::bank_rsp_t rsp,
	output mem_types_pkg::sram_bus_t ram2,
	input logic [mem_types_pkg::word_w-1:0] ram2_dq_in
);
	import mem_types_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_cycle1,
		st_cycle2
	} phase_t;

	phase_t phase;

	logic en_n_q;
	logic oe_n_q;
	logic we_n_q;
	logic data_oe_q;
	logic done_q;
	logic [sram_addr_w-1:0] addr_q;
	logic [word_w-1:0] wdata_q;
	logic [word_w-1:0] rdata_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= st_idle;
			en_n_q <= 1'b1;
			oe_n_q <= 1'b1;
			we_n_q <= 1'b1;
			data_oe_q <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (phase)
				st_idle: begin
					if (req.valid) begin
						phase <= st_cycle1;
						en_n_q <= 1'b0;
						oe_n_q <= req.write;
						we_n_q <= !req.write;
						data_oe_q <= req.write;
					end
				end
				st_cycle1: begin
					phase <= st_cycle2;
					en_n_q <= 1'b1;
					oe_n_q <= 1'b1;
					we_n_q <= 1'b1;
				end
				st_cycle2: begin
					phase <= st_idle;
					data_oe_q <= 1'b0;
					done_q <= 1'b1;
				end
				default: phase <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (phase == st_idle && req.valid) begin
			addr_q <= {{(sram_addr_w - word_w){1'b0}}, req.addr.word};
			wdata_q <= req.wdata;
		end
		// sram output settled by the end of the strobe cycle
		if (phase == st_cycle1)
			rdata_q <= ram2_dq_in;
	end

	assign ram2 = '{addr: addr_q, en_n: en_n_q, oe_n: oe_n_q, we_n: we_n_q,
			data_out: wdata_q, data_oe: data_oe_q};
	assign rsp = '{done: done_q, err: 1'b0, rdata: rdata_q};

	oe_we_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(!ram2.oe_n && !ram2.we_n))
		else $error("ram2 oe_n and we_n low together");

endmodule

//--- ram_controller.sv
module ram_controller (
	input logic clk,
	input logic rst_n,
	input axi_lite_pkg::axi_lite_req_t axi_req,
	output axi_lite_pkg::axi_lite_rsp_t axi_rsp,
	output mem_types_pkg::bank_req_t ram1_req,
	input mem_types_pkg::bank_rsp_t ram1_rsp,
	output mem_types_pkg::bank_req_t ram2_req,
	input mem_types_pkg::bank_rsp_t ram2_rsp
);
	import axi_lite_pkg::*;
	import mem_types_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_dispatch,
		st_wait,
		st_respond
	} state_t;

	state_t state;

	logic take_read;
	logic take_write;
	logic rsp_taken;
	logic [word_w-1:0] acc_word;
	logic is_write_q;
	logic sel_ram2_q;
	logic err_q;
	mem_addr_u addr_q;
	logic [word_w-1:0] wdata_q;
	logic [word_w-1:0] rdata_q;
	bank_req_t dispatch_req;
	bank_rsp_t bank_rsp;

	// read wins when both channels are valid in the same idle cycle
	assign take_read = state == st_idle && axi_req.arvalid;
	assign take_write = state == st_idle && !axi_req.arvalid && axi_req.awvalid && axi_req.wvalid;

	assign acc_word = take_read ? axi_req.araddr[axi_word_msb:axi_word_lsb]
				    : axi_req.awaddr[axi_word_msb:axi_word_lsb];

	assign rsp_taken = is_write_q ? axi_req.bready : axi_req.rready;

	// only the selected engine can answer
	assign bank_rsp = sel_ram2_q ? ram2_rsp : ram1_rsp;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			is_write_q <= 1'b0;
			sel_ram2_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (take_read || take_write) begin
						state <= st_dispatch;
						is_write_q <= take_write;
						sel_ram2_q <= acc_word < ram2_limit;
					end
				end
				st_dispatch: state <= st_wait;
				st_wait: begin
					if (bank_rsp.done) begin
						state <= st_respond;
						err_q <= bank_rsp.err;
					end
				end
				st_respond: begin
					if (rsp_taken)
						state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take_read || take_write) begin
			addr_q.word <= acc_word;
			wdata_q <= axi_req.wdata[word_w-1:0];
		end
		if (state == st_wait && bank_rsp.done)
			rdata_q <= bank_rsp.rdata;
	end

	// one-cycle request pulse to the chosen bank
	always_comb begin
		dispatch_req.valid = state == st_dispatch;
		dispatch_req.write = is_write_q;
		dispatch_req.addr = addr_q;
		dispatch_req.wdata = wdata_q;
		ram1_req = dispatch_req;
		ram1_req.valid = dispatch_req.valid && !sel_ram2_q;
		ram2_req = dispatch_req;
		ram2_req.valid = dispatch_req.valid && sel_ram2_q;
	end

	always_comb begin
		axi_rsp.awready = take_write;
		axi_rsp.wready = take_write;
		axi_rsp.arready = take_read;
		axi_rsp.bvalid = state == st_respond && is_write_q;
		axi_rsp.bresp = err_q ? resp_slverr : resp_okay;
		axi_rsp.rvalid = state == st_respond && !is_write_q;
		axi_rsp.rdata = {{(axi_data_w - word_w){1'b0}}, rdata_q};
		axi_rsp.rresp = err_q ? resp_slverr : resp_okay;
	end

	one_bank_at_a_time: assert property (@(posedge clk) disable iff (!rst_n)
		!(ram1_req.valid && ram2_req.valid))
		else $error("both bank requests valid together");

	// engines only answer a dispatched request
	no_done_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		state == st_idle |-> !(ram1_rsp.done || ram2_rsp.done))
		else $error("bank done while controller idle");

endmodule

//--- ram_uart.sv
module ram_uart (
	input logic clk,
	input logic rst_n,
	input mem_types_pkg::bank_req_t req,
	output mem_types_pkg::bank_rsp_t rsp,
	output mem_types_pkg::sram_bus_t ram1,
	input logic [mem_types_pkg::word_w-1:0] ram1_dq_in,
	input logic data_ready,
	input logic tbre,
	input logic tsre,
	output logic rdn,
	output logic wrn
);
	import mem_types_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_cycle1,
		st_cycle2,
		st_status
	} phase_t;

	phase_t phase;

	logic io_hit;
	logic uart_data_hit;
	logic uart_stat_hit;
	logic [word_w-1:0] status_word;
	logic stat_write_q;
	logic en_n_q;
	logic oe_n_q;
	logic we_n_q;
	logic data_oe_q;
	logic rdn_q;
	logic wrn_q;
	logic done_q;
	logic err_q;
	logic [sram_addr_w-1:0] addr_q;
	logic [word_w-1:0] wdata_q;
	logic [word_w-1:0] rdata_q;

	// uart registers live on the io page
	assign io_hit = req.addr.io.page == io_page;
	assign uart_data_hit = io_hit && req.addr.io.regsel == uart_data_reg;
	assign uart_stat_hit = io_hit && req.addr.io.regsel == uart_stat_reg;

	// bit 0 transmitter empty, bit 1 receive data ready
	assign status_word = {{(word_w - 2){1'b0}}, data_ready, tbre && tsre};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= st_idle;
			stat_write_q <= 1'b0;
			en_n_q <= 1'b1;
			oe_n_q <= 1'b1;
			we_n_q <= 1'b1;
			data_oe_q <= 1'b0;
			rdn_q <= 1'b1;
			wrn_q <= 1'b1;
			done_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			err_q <= 1'b0;
			case (phase)
				st_idle: begin
					if (req.valid) begin
						if (uart_stat_hit) begin
							phase <= st_status;
							stat_write_q <= req.write;
						end else if (uart_data_hit) begin
							// ram1 stays disabled, uart drives or reads the bus
							phase <= st_cycle1;
							rdn_q <= req.write;
							wrn_q <= !req.write;
							data_oe_q <= req.write;
						end else begin
							phase <= st_cycle1;
							en_n_q <= 1'b0;
							oe_n_q <= req.write;
							we_n_q <= !req.write;
							data_oe_q <= req.write;
						end
					end
				end
				st_cycle1: begin
					phase <= st_cycle2;
					en_n_q <= 1'b1;
					oe_n_q <= 1'b1;
					we_n_q <= 1'b1;
					rdn_q <= 1'b1;
					wrn_q <= 1'b1;
				end
				st_cycle2: begin
					// write data held one cycle past the strobe
					phase <= st_idle;
					data_oe_q <= 1'b0;
					done_q <= 1'b1;
				end
				st_status: begin
					// status register is read only
					phase <= st_idle;
					done_q <= 1'b1;
					err_q <= stat_write_q;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (phase == st_idle && req.valid) begin
			addr_q <= {{(sram_addr_w - word_w){1'b0}}, req.addr.word};
			wdata_q <= req.wdata;
		end
		// shared data bus, same sample point for sram and uart
		if (phase == st_cycle1)
			rdata_q <= ram1_dq_in;
		if (phase == st_status)
			rdata_q <= status_word;
	end

	assign ram1 = '{addr: addr_q, en_n: en_n_q, oe_n: oe_n_q, we_n: we_n_q,
			data_out: wdata_q, data_oe: data_oe_q};
	assign rdn = rdn_q;
	assign wrn = wrn_q;
	assign rsp = '{done: done_q, err: err_q, rdata: rdata_q};

	no_bus_fight: assert property (@(posedge clk) disable iff (!rst_n)
		!(!rdn && !ram1.oe_n))
		else $error("uart read and ram1 output enable active together");

endmodule

//--- tb_clock.sv
module tb_clock (
	output logic clk,
	output logic rst_n
);
	localparam int period = 100;
	localparam int reset_cycles = 5;

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// release on a falling edge, like every other input
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

//--- tb_mem_system.sv
module tb_mem_system;
	import mem_types_pkg::*;
	import axi_lite_pkg::*;

	typedef struct packed {
		logic tbre;
		logic tsre;
		logic data_ready;
		logic [7:0] rx_byte;
	} uart_state_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0] resp;
	} rd_exp_t;

	localparam int n_ram2 = 16;
	localparam int n_ram1 = 16;
	localparam int n_stat = 8;
	localparam int n_bp = 12;
	localparam int plan_txn = 2 * n_ram2 + 2 * n_ram1 + n_stat + 3 + 2 * n_bp;
	localparam int watchdog_time = (plan_txn * 30 + 5) * 100;

	logic clk;
	logic rst_n;
	axi_lite_req_t axi_req;
	axi_lite_rsp_t axi_rsp;
	sram_bus_t ram1;
	sram_bus_t ram2;
	logic [15:0] ram1_dq_in;
	logic [15:0] ram1_dq_model;
	logic [15:0] ram2_dq_in;
	logic tbre;
	logic tsre;
	logic data_ready;
	logic rdn;
	logic wrn;

	uart_state_t uart;
	logic [7:0] uart_tx_byte;
	int uart_tx_count = 0;
	int strobe_cycles = 0;
	int fail_count = 0;
	logic [31:0] rng = 32'h13f4c832;
	logic [15:0] shadow [int];
	rd_exp_t rd_exp_q [$];
	logic [1:0] wr_exp_q [$];
	rd_exp_t rd_head;

	tb_clock clock_i (.clk(clk), .rst_n(rst_n));
	tb_sram_model ram1_model (.bus(ram1), .dq_in(ram1_dq_model));
	tb_sram_model ram2_model (.bus(ram2), .dq_in(ram2_dq_in));

	mem_system mem_system_i (
		.clk(clk),
		.rst_n(rst_n),
		.axi_req(axi_req),
		.axi_rsp(axi_rsp),
		.ram1(ram1),
		.ram1_dq_in(ram1_dq_in),
		.ram2(ram2),
		.ram2_dq_in(ram2_dq_in),
		.data_ready(data_ready),
		.tbre(tbre),
		.tsre(tsre),
		.rdn(rdn),
		.wrn(wrn)
	);

	// uart model shares the ram1 data bus, low byte only
	assign ram1_dq_in = !rdn ? {8'h00, uart.rx_byte} : ram1_dq_model;
	assign tbre = uart.tbre;
	assign tsre = uart.tsre;
	assign data_ready = uart.data_ready;

	always @(posedge wrn) begin
		if (ram1.data_oe) begin
			uart_tx_byte <= ram1.data_out[7:0];
			uart_tx_count <= uart_tx_count + 1;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	// address map: uart data, uart status, else whichever sram bank holds the word
	function automatic logic [15:0] expected_read(input logic [15:0] word,
			input logic [15:0] mem [int], input uart_state_t u);
		if (word == 16'hBF00)
			return {8'h00, u.rx_byte};
		if (word == 16'hBF01)
			return {14'b0, u.data_ready, u.tbre && u.tsre};
		if (mem.exists(int'(word)))
			return mem[int'(word)];
		return 16'h0000;
	endfunction

	function automatic logic [1:0] expected_bresp(input logic [15:0] word);
		return (word == 16'hBF01) ? 2'b10 : 2'b00;
	endfunction

	task automatic check(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			fail_count++;
			$display("CHECK FAILED %s actual %h expected %h", name, actual, expected);
			$display("Regression failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// response side, driven by the ready the stimulus raises
	always @(posedge clk) begin
		if (rst_n && axi_rsp.rvalid && axi_req.rready) begin
			if (rd_exp_q.size() == 0) begin
				$display("a read response arrived with no read outstanding");
				$display("Regression failed");
				$fatal(1, "unexpected read response");
			end else begin
				rd_head = rd_exp_q.pop_front();
				check("rdata", axi_rsp.rdata, rd_head.data);
				check("rresp", {30'b0, axi_rsp.rresp}, {30'b0, rd_head.resp});
			end
		end
		if (rst_n && axi_rsp.bvalid && axi_req.bready) begin
			if (wr_exp_q.size() == 0) begin
				$display("a write response arrived with no write outstanding");
				$display("Regression failed");
				$fatal(1, "unexpected write response");
			end else begin
				check("bresp", {30'b0, axi_rsp.bresp}, {30'b0, wr_exp_q.pop_front()});
			end
		end
	end

	// strobe activity, and ram1 must stay off while the uart owns the bus
	always @(posedge clk) begin
		if (rst_n && (!ram1.en_n || !ram1.oe_n || !ram1.we_n || !ram2.en_n
				|| !ram2.oe_n || !ram2.we_n || !rdn || !wrn))
			strobe_cycles <= strobe_cycles + 1;
		if (rst_n && (!rdn || !wrn))
			check("ram1.en_n", {31'b0, ram1.en_n}, 32'h1);
	end

	initial begin
		#(watchdog_time);
		$display("the run timed out after %0d time units without finishing", watchdog_time);
		$display("Regression failed");
		$fatal(1, "watchdog expired");
	end

	// hold ready low for a while, with a competing request on one channel
	task automatic wait_response(input logic is_write, input int hold);
		logic [31:0] held_data;
		logic [1:0] held_resp;
		logic [31:0] r;
		do @(posedge clk); while (!(is_write ? axi_rsp.bvalid : axi_rsp.rvalid));
		held_data = is_write ? 32'h0 : axi_rsp.rdata;
		held_resp = is_write ? axi_rsp.bresp : axi_rsp.rresp;
		for (int i = 0; i < hold; i++) begin
			@(negedge clk);
			r = next_rand();
			// either a competing read or a competing write
			axi_req.arvalid = r[16];
			axi_req.awvalid = !r[16];
			axi_req.wvalid = !r[16];
			axi_req.araddr = {14'b0, r[15:0], 2'b00};
			axi_req.awaddr = {14'b0, r[15:0], 2'b00};
			axi_req.wdata = r;
			@(posedge clk);
			check("arready", {31'b0, axi_rsp.arready}, 32'h0);
			check("awready", {31'b0, axi_rsp.awready}, 32'h0);
			check("wready", {31'b0, axi_rsp.wready}, 32'h0);
			if (is_write) begin
				check("bvalid", {31'b0, axi_rsp.bvalid}, 32'h1);
				check("bresp", {30'b0, axi_rsp.bresp}, {30'b0, held_resp});
			end else begin
				check("rvalid", {31'b0, axi_rsp.rvalid}, 32'h1);
				check("rresp", {30'b0, axi_rsp.rresp}, {30'b0, held_resp});
				check("rdata", axi_rsp.rdata, held_data);
			end
		end
		@(negedge clk);
		axi_req.arvalid = 1'b0;
		axi_req.awvalid = 1'b0;
		axi_req.wvalid = 1'b0;
		axi_req.bready = is_write;
		axi_req.rready = !is_write;
		@(posedge clk);
		@(negedge clk);
		axi_req.bready = 1'b0;
		axi_req.rready = 1'b0;
	endtask

	task automatic do_write(input logic [15:0] word, input logic [15:0] data, input int hold);
		logic [31:0] r;
		wr_exp_q.push_back(expected_bresp(word));
		if (word != 16'hBF00 && word != 16'hBF01)
			shadow[int'(word)] = data;
		r = next_rand();
		@(negedge clk);
		axi_req.awvalid = 1'b1;
		axi_req.wvalid = 1'b1;
		axi_req.awaddr = {14'b0, word, 2'b00};
		// upper half carries junk the DUT must ignore
		axi_req.wdata = {r[31:16], data};
		axi_req.wstrb = 4'hf;
		do @(posedge clk); while (!axi_rsp.awready);
		check("wready", {31'b0, axi_rsp.wready}, 32'h1);
		@(negedge clk);
		axi_req.awvalid = 1'b0;
		axi_req.wvalid = 1'b0;
		wait_response(1'b1, hold);
	endtask

	task automatic do_read(input logic [15:0] word, input int hold);
		rd_exp_q.push_back('{data: {16'h0, expected_read(word, shadow, uart)}, resp: 2'b00});
		@(negedge clk);
		axi_req.arvalid = 1'b1;
		axi_req.araddr = {14'b0, word, 2'b00};
		do @(posedge clk); while (!axi_rsp.arready);
		@(negedge clk);
		axi_req.arvalid = 1'b0;
		wait_response(1'b0, hold);
	endtask

	function automatic logic [15:0] ram1_word(input logic [31:0] r);
		logic [15:0] w;
		w = {1'b1, r[14:0]};
		if (w == 16'hBF00 || w == 16'hBF01)
			w = w ^ 16'h0010;
		return w;
	endfunction

	initial begin
		logic [31:0] r;
		logic [15:0] word;
		logic [15:0] data;
		int writes_before;
		int strobes_before;
		int tx_before;
		logic [15:0] words [$];

		axi_req = '0;
		uart = '0;
		wait (rst_n === 1'b1);
		@(negedge clk);
		check("awready", {31'b0, axi_rsp.awready}, 32'h0);
		check("wready", {31'b0, axi_rsp.wready}, 32'h0);
		check("bvalid", {31'b0, axi_rsp.bvalid}, 32'h0);
		check("arready", {31'b0, axi_rsp.arready}, 32'h0);
		check("rvalid", {31'b0, axi_rsp.rvalid}, 32'h0);
		check("ram1 en_n oe_n we_n", {29'b0, ram1.en_n, ram1.oe_n, ram1.we_n}, 32'h7);
		check("ram2 en_n oe_n we_n", {29'b0, ram2.en_n, ram2.oe_n, ram2.we_n}, 32'h7);
		check("rdn wrn", {30'b0, rdn, wrn}, 32'h3);
		check("data_oe", {30'b0, ram1.data_oe, ram2.data_oe}, 32'h0);

		// ram2 region
		writes_before = ram1_model.write_count;
		for (int i = 0; i < n_ram2; i++) begin
			r = next_rand();
			word = {1'b0, r[14:0]};
			data = r[31:16];
			words.push_back(word);
			do_write(word, data, 0);
			check("ram2 model word", {16'h0, ram2_model.mem[word]}, {16'h0, data});
		end
		foreach (words[i]) do_read(words[i], 0);
		check("ram1 model writes", ram1_model.write_count, writes_before);

		// ram1 region
		words.delete();
		writes_before = ram2_model.write_count;
		for (int i = 0; i < n_ram1; i++) begin
			r = next_rand();
			word = ram1_word(r);
			data = r[31:16];
			words.push_back(word);
			do_write(word, data, 0);
			check("ram1 model word", {16'h0, ram1_model.mem[word]}, {16'h0, data});
		end
		foreach (words[i]) do_read(words[i], 0);
		check("ram2 model writes", ram2_model.write_count, writes_before);

		// uart data write, status reads, data read
		writes_before = ram1_model.write_count;
		tx_before = uart_tx_count;
		r = next_rand();
		do_write(16'hBF00, r[15:0], 0);
		check("uart tx count", uart_tx_count, tx_before + 1);
		check("uart tx byte", {24'h0, uart_tx_byte}, {24'h0, r[7:0]});
		for (int i = 0; i < n_stat; i++) begin
			r = next_rand();
			@(negedge clk);
			uart.tbre = r[0];
			uart.tsre = r[1];
			uart.data_ready = r[2];
			do_read(16'hBF01, 0);
		end
		r = next_rand();
		@(negedge clk);
		uart.rx_byte = r[7:0];
		do_read(16'hBF00, 0);
		check("ram1 model writes", ram1_model.write_count, writes_before);

		// status register is read only
		strobes_before = strobe_cycles;
		r = next_rand();
		do_write(16'hBF01, r[15:0], 0);
		check("strobe cycles", strobe_cycles, strobes_before);

		// back-pressure on both banks
		for (int i = 0; i < n_bp; i++) begin
			r = next_rand();
			word = r[3] ? ram1_word(r) : {1'b0, r[14:0]};
			data = r[31:16];
			do_write(word, data, int'(r[6:4]) + 1);
			r = next_rand();
			do_read(word, int'(r[2:0]) + 1);
		end

		repeat (2) @(negedge clk);
		check("outstanding reads", rd_exp_q.size(), 0);
		check("outstanding writes", wr_exp_q.size(), 0);
		if (fail_count == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("Regression failed");
			$fatal(1, "errors were found");
		end
	end

endmodule

//--- tb_sram_model.sv
module tb_sram_model (
	input mem_types_pkg::sram_bus_t bus,
	output logic [mem_types_pkg::word_w-1:0] dq_in
);
	import mem_types_pkg::*;

	logic [word_w-1:0] mem [0:65535];
	int write_count = 0;
	logic write_active;

	// every location starts with a value that depends on its full address
	function automatic logic [word_w-1:0] fill_word(input logic [sram_addr_w-1:0] a);
		return a[15:0] ^ {a[7:0], a[15:8]} ^ {14'b0, a[17:16]} ^ 16'h5a3c;
	endfunction

	initial begin
		for (int i = 0; i < 65536; i++) begin
			mem[i[15:0]] = fill_word(sram_addr_w'(i));
		end
	end

	assign write_active = !bus.en_n && !bus.we_n && bus.data_oe;

	// data is latched as the write strobe ends
	always @(negedge write_active) begin
		if (bus.data_oe === 1'b1) begin
			mem[bus.addr[15:0]] <= bus.data_out;
			write_count <= write_count + 1;
		end
	end

	// pulled-up bus when the chip does not drive it
	assign dq_in = (!bus.en_n && !bus.oe_n) ? mem[bus.addr[15:0]] : '1;

endmodule
